//--- src.f
+incdir+include
verilog/execPkg.sv
verilog/operandForward.sv
verilog/alu.sv
verilog/branchTarget.sv
verilog/pcResolve.sv
verilog/executeStage.sv
bench/executeStage_tb.sv

//--- bench/executeStage_tb.sv
// testbench for executeStage, random instructions checked against a reference model
`timescale 1ns/10ps
`default_nettype none
`include "exec_settings.svh"

module executeStage_tb;
   import execPkg::*;

   localparam int DataW         = `EXEC_DATA_W;
   localparam int NumCycles     = 600;
   localparam int TimeoutCycles = 4 * NumCycles + 50;

   logic    clk;
   logic    rstN;
   logic    inValid;
   logic    stall;
   exIn_t   inst;
   fwdBus_t fwd;
   logic    outValid;
   exOut_t  out;

   integer  seed;
   int      stallLeft;
   int      cycleCount;
   logic    checkOn;
   logic    expValid;
   logic    stallSeen;
   exOut_t  expHead;
   exOut_t  expQ[$];

   executeStage i_dut (
      .clk      (clk),
      .rstN     (rstN),
      .inValid  (inValid),
      .stall    (stall),
      .inst     (inst),
      .fwd      (fwd),
      .outValid (outValid),
      .out      (out)
   );

   always #2 clk = ~clk;

   task automatic reportMismatch(input string name, input logic [DataW-1:0] got,
                                 input logic [DataW-1:0] exp);
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   task automatic reportProblem(input string what);
      $display("%s", what);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   // value an operand should take after forwarding
   function automatic logic [DataW-1:0] forwardedValue(input fwdSel_t sel,
                                                       input logic [DataW-1:0] regVal,
                                                       input fwdBus_t f);
      logic [DataW-1:0] v;
      v = regVal;
      if (sel.enable) begin
         case (sel.src)
            LINK:    v = sel.fromMem ? f.memLink : f.exLink;
            ALU:     v = sel.fromMem ? f.memAlu : f.exAlu;
            IMM8:    v = sel.fromMem ? f.memImm8 : f.exImm8;
            MEMDATA: v = f.memData;
            default: v = regVal;
         endcase
      end
      return v;
   endfunction

   function automatic exOut_t predictOut(input exIn_t in, input fwdBus_t f);
      logic [DataW-1:0] opA, opB, fwdB, a, b, res, offs, base;
      logic [3:0]       sh;
      integer           sSum;
      logic             ovf, cond, taken;
      exOut_t           o;
      opA  = forwardedValue(in.fwdA, in.regA, f);
      fwdB = forwardedValue(in.fwdB, in.regB, f);
      opB  = in.ctrl.immB ? in.immB : fwdB;
      a    = in.ctrl.invA ? ~opA : opA;
      b    = in.ctrl.invB ? ~opB : opB;
      sh   = opB[3:0];
      // overflow means the signed sum left the 16-bit range
      sSum = $signed(a);
      sSum = sSum + $signed(b);
      if (in.ctrl.cin) sSum = sSum + 1;
      ovf = (sSum > 32767) || (sSum < -32768);
      case (in.ctrl.aluOp)
         ADD:     res = a + b + in.ctrl.cin;
         AND:     res = a & b;
         OR:      res = a | b;
         XOR:     res = a ^ b;
         SLL:     res = a << sh;
         SRL:     res = a >> sh;
         ROL:     res = (a << sh) | (a >> (DataW - sh));
         default: res = b;
      endcase
      case (in.ctrl.cond)
         NEVER:   cond = 1'b0;
         ALWAYS:  cond = 1'b1;
         EQZ:     cond = (res == 0);
         NEZ:     cond = (res != 0);
         LTZ:     cond = res[DataW-1];
         GEZ:     cond = !res[DataW-1];
         LT:      cond = res[DataW-1] != ovf;
         default: cond = (res[DataW-1] != ovf) || (res == 0);
      endcase
      offs = in.ctrl.useJForm ? DataW'($signed(in.imm.jForm.disp11))
                              : DataW'($signed(in.imm.iForm.imm8));
      base  = in.ctrl.baseFromReg ? opA : in.incPc;
      taken = in.ctrl.jump || cond;
      o.result     = in.ctrl.link ? in.incPc : (in.ctrl.setOp ? DataW'(taken) : res);
      o.storeData  = fwdB;
      o.nextPc     = taken ? base + offs : in.incPc;
      o.redirect   = taken;
      o.mispredict = in.ctrl.branchInst && taken;
      return o;
   endfunction

   // new instruction unless the stage stalled, then the held one stays
   task automatic driveNext();
      logic [127:0] raw;
      exIn_t        next;
      raw = {$random(seed), $random(seed), $random(seed), $random(seed)};
      fwd <= fwdBus_t'(raw[$bits(fwdBus_t)-1:0]);
      if (!stall) begin
         raw  = {$random(seed), $random(seed), $random(seed), $random(seed)};
         next = exIn_t'(raw[$bits(exIn_t)-1:0]);
         // equal operands now and then, so zero results show up
         if (($random(seed) & 3) == 0) begin
            next.fwdA.enable = 1'b0;
            next.fwdB.enable = 1'b0;
            next.regB        = next.regA;
            next.immB        = next.regA;
         end
         inst    <= next;
         inValid <= ($random(seed) & 7) != 0;
      end
      if (stallLeft == 0 && ($random(seed) & 7) == 0) stallLeft = 1 + ($random(seed) & 3);
      stall <= (stallLeft != 0);
      if (stallLeft != 0) stallLeft = stallLeft - 1;
   endtask

   // inputs seen here are the ones the DUT samples on this edge
   always @(posedge clk) begin
      if (!rstN) begin
         checkOn   <= 1'b1;
         expValid  <= 1'b0;
         stallSeen <= 1'b0;
      end else begin
         stallSeen <= stall;
         if (!stall) begin
            expValid <= inValid;
            if (inValid) begin
               expQ.push_back(predictOut(inst, fwd));
               expHead <= expQ[0];
            end
         end
      end
   end

   // a fresh output retires the oldest expected entry after the checks sampled it
   always @(negedge clk) begin
      if (checkOn && outValid && !stallSeen) begin
         if (expQ.size() == 0) begin
            reportProblem("output appeared with no accepted instruction");
         end else begin
            void'(expQ.pop_front());
         end
      end
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TimeoutCycles) begin
         $display("run did not finish within %0d cycles", TimeoutCycles);
         $display("*** TEST FAILED ***");
         $fatal(1);
      end
   end

   // outputs are checked mid-cycle, away from the driving edge
   aValid: assert property (@(negedge clk) disable iff (!checkOn) outValid == expValid)
      else reportMismatch("outValid", outValid, expValid);
   aResult: assert property (@(negedge clk) disable iff (!checkOn)
      expValid |-> out.result == expHead.result)
      else reportMismatch("out.result", out.result, expHead.result);
   aStore: assert property (@(negedge clk) disable iff (!checkOn)
      expValid |-> out.storeData == expHead.storeData)
      else reportMismatch("out.storeData", out.storeData, expHead.storeData);
   aNextPc: assert property (@(negedge clk) disable iff (!checkOn)
      expValid |-> out.nextPc == expHead.nextPc)
      else reportMismatch("out.nextPc", out.nextPc, expHead.nextPc);
   aRedirect: assert property (@(negedge clk) disable iff (!checkOn)
      expValid |-> out.redirect == expHead.redirect)
      else reportMismatch("out.redirect", out.redirect, expHead.redirect);
   aMispredict: assert property (@(negedge clk) disable iff (!checkOn)
      expValid |-> out.mispredict == expHead.mispredict)
      else reportMismatch("out.mispredict", out.mispredict, expHead.mispredict);
   aIdle: assert property (@(negedge clk) disable iff (!checkOn)
      !expValid |-> !out.redirect && !out.mispredict)
      else reportProblem("redirect or mispredict set with no valid instruction");
   aHold: assert property (@(negedge clk) disable iff (!checkOn)
      stallSeen |-> $stable(out) && $stable(outValid))
      else reportProblem("output register changed during a stall");

   initial begin
      seed       = 25;
      clk        = 1'b0;
      rstN       = 1'b0;
      inValid    = 1'b0;
      stall      = 1'b0;
      inst       = '0;
      fwd        = '0;
      stallLeft  = 0;
      cycleCount = 0;
      checkOn    = 1'b0;
      expValid   = 1'b0;
      stallSeen  = 1'b0;
      expHead    = '0;
      repeat (5) @(posedge clk);
      rstN <= 1'b1;
      for (int i = 0; i < NumCycles; i++) begin
         @(posedge clk);
         driveNext();
      end
      @(posedge clk);
      inValid <= 1'b0;
      stall   <= 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      if (expQ.size() == 0) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         $display("expected results left over after the run");
         $display("*** TEST FAILED ***");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
// execute stage top, wires forwarding, ALU, target and resolve into the EX/MEM register
`timescale 1ns/10ps
`default_nettype none
`include "exec_settings.svh"

module executeStage (
   input  wire logic             clk,
   input  wire logic             rstN,
   input  wire logic             inValid,
   input  wire logic             stall,
   input  wire execPkg::exIn_t   inst,
   input  wire execPkg::fwdBus_t fwd,
   output logic                  outValid,
   output execPkg::exOut_t       out
);
   import execPkg::*;

   logic [`EXEC_DATA_W-1:0] opA;
   logic [`EXEC_DATA_W-1:0] opB;
   logic [`EXEC_DATA_W-1:0] storeData;
   logic [`EXEC_DATA_W-1:0] aluResult;
   logic [`EXEC_DATA_W-1:0] target;
   aluFlags_t               flags;
   exOut_t                  resolved;
   logic                    accept;

   // EX/MEM register pieces
   logic                    redirectQ;
   logic                    mispredictQ;
   logic [`EXEC_DATA_W-1:0] resultQ;
   logic [`EXEC_DATA_W-1:0] storeDataQ;
   logic [`EXEC_DATA_W-1:0] nextPcQ;

   operandForward i_operandForward (
      .inst      (inst),
      .fwd       (fwd),
      .opA       (opA),
      .opB       (opB),
      .storeData (storeData)
   );

   alu i_alu (
      .opA    (opA),
      .opB    (opB),
      .aluOp  (inst.ctrl.aluOp),
      .invA   (inst.ctrl.invA),
      .invB   (inst.ctrl.invB),
      .cin    (inst.ctrl.cin),
      .result (aluResult),
      .flags  (flags)
   );

   branchTarget i_branchTarget (
      .incPc       (inst.incPc),
      .baseReg     (opA),
      .imm         (inst.imm),
      .useJForm    (inst.ctrl.useJForm),
      .baseFromReg (inst.ctrl.baseFromReg),
      .target      (target)
   );

   pcResolve i_pcResolve (
      .ctrl      (inst.ctrl),
      .incPc     (inst.incPc),
      .aluResult (aluResult),
      .flags     (flags),
      .target    (target),
      .resolved  (resolved)
   );

   assign accept = inValid & ~stall;

   // a bubble clears valid and the redirect bits, stall holds everything
   always_ff @(posedge clk) begin
      if (!rstN) begin
         outValid    <= 1'b0;
         redirectQ   <= 1'b0;
         mispredictQ <= 1'b0;
      end else if (!stall) begin
         outValid    <= inValid;
         redirectQ   <= inValid & resolved.redirect;
         mispredictQ <= inValid & resolved.mispredict;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         resultQ    <= resolved.result;
         storeDataQ <= storeData;
         nextPcQ    <= resolved.nextPc;
      end
   end

   assign out = '{result:     resultQ,
                  storeData:  storeDataQ,
                  nextPc:     nextPcQ,
                  redirect:   redirectQ,
                  mispredict: mispredictQ};

endmodule

`default_nettype wire

//--- verilog/pcResolve.sv
// branch resolution, picks next PC, result word and misprediction from flags and target
`timescale 1ns/10ps
`default_nettype none
`include "exec_settings.svh"

module pcResolve (
   input  wire execPkg::exCtrl_t        ctrl,
   input  wire logic [`EXEC_DATA_W-1:0] incPc,
   input  wire logic [`EXEC_DATA_W-1:0] aluResult,
   input  wire execPkg::aluFlags_t      flags,
   input  wire logic [`EXEC_DATA_W-1:0] target,
   output execPkg::exOut_t              resolved
);
   import execPkg::*;

   logic condMet;
   logic taken;

   // signed compares assume a subtract was done in the ALU
   always_comb begin
      case (ctrl.cond)
         NEVER:   condMet = 1'b0;
         ALWAYS:  condMet = 1'b1;
         EQZ:     condMet = flags.zero;
         NEZ:     condMet = ~flags.zero;
         LTZ:     condMet = flags.sign;
         GEZ:     condMet = ~flags.sign;
         LT:      condMet = flags.sign ^ flags.ovf;
         LE:      condMet = (flags.sign ^ flags.ovf) | flags.zero;
         default: condMet = 1'b0;
      endcase
   end

   assign taken = ctrl.jump | condMet;

   always_comb begin
      resolved.nextPc     = taken ? target : incPc;
      resolved.redirect   = taken;
      // predict not taken, so every taken branch is a miss
      resolved.mispredict = ctrl.branchInst & taken;

      // link wins over set, set wins over ALU
      if (ctrl.link) begin
         resolved.result = incPc;
      end else if (ctrl.setOp) begin
         resolved.result = {{(`EXEC_DATA_W-1){1'b0}}, taken};
      end else begin
         resolved.result = aluResult;
      end

      // store data comes from the forwarding block at the top
      resolved.storeData = '0;
   end

endmodule

`default_nettype wire

//--- verilog/branchTarget.sv
// branch and jump target adder, PC-relative or register-relative for JR/SLBI style ops
`timescale 1ns/10ps
`default_nettype none
`include "exec_settings.svh"

module branchTarget (
   input  wire logic [`EXEC_DATA_W-1:0] incPc,
   input  wire logic [`EXEC_DATA_W-1:0] baseReg,
   input  wire execPkg::immField_u      imm,
   input  wire logic                    useJForm,
   input  wire logic                    baseFromReg,
   output logic [`EXEC_DATA_W-1:0]      target
);
   import execPkg::*;

   localparam int DataW  = `EXEC_DATA_W;
   localparam int Imm8W  = `EXEC_IMM8_W;
   localparam int Imm11W = `EXEC_IMM11_W;

   logic [DataW-1:0] ext8;
   logic [DataW-1:0] ext11;
   logic [DataW-1:0] offset;
   logic [DataW-1:0] base;

   // sign-extend both views, useJForm decides which one is meant
   assign ext8  = {{(DataW-Imm8W){imm.iForm.imm8[Imm8W-1]}}, imm.iForm.imm8};
   assign ext11 = {{(DataW-Imm11W){imm.jForm.disp11[Imm11W-1]}}, imm.jForm.disp11};

   assign offset = useJForm ? ext11 : ext8;

   // register base is the forwarded operand A
   assign base = baseFromReg ? baseReg : incPc;

   // carry out dropped, addresses wrap
   assign target = base + offset;

endmodule

`default_nettype wire

//--- verilog/alu.sv
// 16-bit ALU of the execute stage, add/logic/shift/rotate with flags for branch checks
`timescale 1ns/10ps
`default_nettype none
`include "exec_settings.svh"

module alu (
   input  wire logic [`EXEC_DATA_W-1:0] opA,
   input  wire logic [`EXEC_DATA_W-1:0] opB,
   input  wire execPkg::aluOp_e         aluOp,
   input  wire logic                    invA,
   input  wire logic                    invB,
   input  wire logic                    cin,
   output logic [`EXEC_DATA_W-1:0]      result,
   output execPkg::aluFlags_t           flags
);
   import execPkg::*;

   localparam int DataW = `EXEC_DATA_W;
   localparam int ShW   = $clog2(DataW);

   logic [DataW-1:0]   a;
   logic [DataW-1:0]   b;
   logic [DataW:0]     sum;
   logic [ShW-1:0]     shAmt;
   logic [2*DataW-1:0] rotWide;

   // inverted operands feed every op, subtract is invB with cin
   assign a = invA ? ~opA : opA;
   assign b = invB ? ~opB : opB;

   assign sum     = {1'b0, a} + {1'b0, b} + {{DataW{1'b0}}, cin};
   assign shAmt   = opB[ShW-1:0];
   assign rotWide = {a, a} << shAmt;

   always_comb begin
      case (aluOp)
         ADD:     result = sum[DataW-1:0];
         AND:     result = a & b;
         OR:      result = a | b;
         XOR:     result = a ^ b;
         SLL:     result = a << shAmt;
         SRL:     result = a >> shAmt;
         // upper half of the doubled word is the rotated value
         ROL:     result = rotWide[2*DataW-1:DataW];
         PASSB:   result = b;
         default: result = sum[DataW-1:0];
      endcase
   end

   // carry and overflow always come from the adder
   always_comb begin
      flags.zero  = (result == '0);
      flags.sign  = result[DataW-1];
      flags.carry = sum[DataW];
      flags.ovf   = (a[DataW-1] == b[DataW-1]) && (sum[DataW-1] != a[DataW-1]);
   end

endmodule

`default_nettype wire

//--- verilog/operandForward.sv
// operand mux in front of the ALU, picks register or forwarded values per operand
`timescale 1ns/10ps
`default_nettype none
`include "exec_settings.svh"

module operandForward (
   input  wire execPkg::exIn_t          inst,
   input  wire execPkg::fwdBus_t        fwd,
   output logic [`EXEC_DATA_W-1:0]      opA,
   output logic [`EXEC_DATA_W-1:0]      opB,
   output logic [`EXEC_DATA_W-1:0]      storeData
);
   import execPkg::*;

   logic [`EXEC_DATA_W-1:0] fwdA;
   logic [`EXEC_DATA_W-1:0] fwdB;

   // value for one operand given its select and register value
   function automatic logic [`EXEC_DATA_W-1:0] pickOperand(
      input fwdSel_t                 sel,
      input logic [`EXEC_DATA_W-1:0] regVal,
      input fwdBus_t                 bus
   );
      logic [`EXEC_DATA_W-1:0] picked;
      picked = regVal;
      if (sel.enable) begin
         case (sel.src)
            LINK:    picked = sel.fromMem ? bus.memLink : bus.exLink;
            ALU:     picked = sel.fromMem ? bus.memAlu : bus.exAlu;
            IMM8:    picked = sel.fromMem ? bus.memImm8 : bus.exImm8;
            // load data only exists from MEM/WB
            MEMDATA: picked = bus.memData;
            default: picked = regVal;
         endcase
      end
      return picked;
   endfunction

   always_comb begin
      fwdA = pickOperand(inst.fwdA, inst.regA, fwd);
      fwdB = pickOperand(inst.fwdB, inst.regB, fwd);
   end

   assign opA = fwdA;

   // immediate takes the B slot, register B still goes out for stores
   assign opB       = inst.ctrl.immB ? inst.immB : fwdB;
   assign storeData = fwdB;

endmodule

`default_nettype wire

//--- verilog/execPkg.sv
// shared types of the execute stage, imported by each RTL module that uses them
`default_nettype none
`include "exec_settings.svh"

package execPkg;

   typedef enum logic [`EXEC_ALUOP_W-1:0] {
      ADD   = 3'd0,
      AND   = 3'd1,
      OR    = 3'd2,
      XOR   = 3'd3,
      SLL   = 3'd4,
      SRL   = 3'd5,
      ROL   = 3'd6,
      PASSB = 3'd7
   } aluOp_e;

   // LT and LE use sign xor overflow
   typedef enum logic [2:0] {
      NEVER, ALWAYS, EQZ, NEZ, LTZ, GEZ, LT, LE
   } brCond_e;

   // two-bit source code of a forwarded value
   typedef enum logic [1:0] {
      LINK    = 2'b00,
      MEMDATA = 2'b01,
      ALU     = 2'b10,
      IMM8    = 2'b11
   } fwdSrc_e;

   typedef struct packed {
      logic    enable;
      logic    fromMem;    // 0 for EX/MEM, 1 for MEM/WB
      fwdSrc_e src;
   } fwdSel_t;

   typedef struct packed {
      logic [`EXEC_DATA_W-1:0] exAlu;
      logic [`EXEC_DATA_W-1:0] exImm8;
      logic [`EXEC_DATA_W-1:0] exLink;
      logic [`EXEC_DATA_W-1:0] memAlu;
      logic [`EXEC_DATA_W-1:0] memImm8;
      logic [`EXEC_DATA_W-1:0] memLink;
      logic [`EXEC_DATA_W-1:0] memData;
   } fwdBus_t;

   // one 11-bit field, read as I-form or J-form
   typedef union packed {
      struct packed {
         logic [`EXEC_RD_W-1:0]    rd;
         logic [`EXEC_IMM8_W-1:0]  imm8;
      } iForm;
      struct packed {
         logic [`EXEC_IMM11_W-1:0] disp11;
      } jForm;
   } immField_u;

   typedef struct packed {
      aluOp_e  aluOp;
      logic    invA;
      logic    invB;
      logic    cin;
      logic    immB;         // B is the immediate, forwarded B becomes store data
      logic    useJForm;
      logic    baseFromReg;  // target base is operand A, not the PC
      brCond_e cond;
      logic    branchInst;
      logic    jump;
      logic    setOp;        // result is the condition bit
      logic    link;         // result is the incremented PC
   } exCtrl_t;

   typedef struct packed {
      exCtrl_t                 ctrl;
      logic [`EXEC_DATA_W-1:0] incPc;
      logic [`EXEC_DATA_W-1:0] regA;
      logic [`EXEC_DATA_W-1:0] regB;
      logic [`EXEC_DATA_W-1:0] immB;
      immField_u               imm;
      fwdSel_t                 fwdA;
      fwdSel_t                 fwdB;
   } exIn_t;

   typedef struct packed {
      logic [`EXEC_DATA_W-1:0] result;
      logic [`EXEC_DATA_W-1:0] storeData;
      logic [`EXEC_DATA_W-1:0] nextPc;
      logic                    redirect;
      logic                    mispredict;
   } exOut_t;

   typedef struct packed {
      logic zero;
      logic sign;
      logic ovf;
      logic carry;
   } aluFlags_t;

endpackage

`default_nettype wire

//--- include/exec_settings.svh
// width settings for the execute stage, included by the package and every RTL module
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// datapath word
`define EXEC_DATA_W 16

// immediate views carried in the 11-bit instruction field
`define EXEC_IMM8_W 8
`define EXEC_IMM11_W 11

// destination register field beside imm8 in the I-form view
`define EXEC_RD_W 3

// ALU operation select
`define EXEC_ALUOP_W 3

`endif
